//--- design/multisim_cfg_pkg.sv
// poll server configuration: payload widths and the adaptive poll delay bounds
package multisim_cfg_pkg;

  // payload widths of the host command and the client response
  localparam int cmd_width = 32;
  localparam int rsp_width = 32;

  // longest wait between host polls
  // used after reset and as the cap of the backoff
  localparam int delay_inactive = 64;

  // short wait after a poll that brought work,
  // keeps back to back transactions fast
  localparam int delay_active = 2;

  // width of the delay counter, must hold delay_inactive
  localparam int delay_width = 7;

endpackage

//--- design/multisim_msg_pkg.sv
// poll server message types: command and response words and the wait count
package multisim_msg_pkg;

  import multisim_cfg_pkg::*;

  // one command word as pulled from the host and handed to the client
  typedef logic [cmd_width-1:0] cmd_t;

  // one response word as pushed by the client and returned to the host
  typedef logic [rsp_width-1:0] rsp_t;

  // unsigned wait count in clock cycles
  // delay_inactive is the largest value it has to hold
  typedef logic [delay_width-1:0] delay_t;

endpackage

//--- design/multisim_poll_if.sv
// poll link between the server core and the command fetch side
`timescale 1ns/1ps

interface multisim_poll_if
  import multisim_msg_pkg::*;
();

  // one cycle strobe, core asks for a host poll
  logic poll;
  // one cycle strobe, the host answered the outstanding poll
  logic answer;
  // host had a command, only valid together with answer
  logic hit;
  // command word, only valid together with answer and hit
  cmd_t cmd;

  // core side
  modport requester (
    output poll,
    input  answer,
    input  hit,
    input  cmd
  );

  // fetch side
  modport responder (
    input  poll,
    output answer,
    output hit,
    output cmd
  );

endinterface

//--- design/multisim_poll_scheduler.sv
// poll scheduler: adaptive backoff wait that pulses due when the next poll is due
`timescale 1ns/1ps

module multisim_poll_scheduler
  import multisim_cfg_pkg::*;
  import multisim_msg_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic kick,
  input  logic hit_kick,
  output logic due
);

  // delay of the wait in progress, base of the next backoff step
  delay_t cur_delay;
  // cycles left in the current wait
  delay_t count;
  // a wait is in progress
  logic running;
  // delay loaded on a kick
  delay_t next_delay;
  // cur_delay times four, two extra bits so the product cannot wrap
  logic [delay_width+1:0] quad;

  // backoff step, a zero delay counts as one
  always_comb begin
    if (cur_delay == '0) begin
      quad = (delay_width + 2)'(4);
    end else begin
      quad = {cur_delay, 2'b00};
    end
    if (hit_kick) begin
      next_delay = delay_t'(delay_active);
    end else if (quad > delay_inactive) begin
      next_delay = delay_t'(delay_inactive);
    end else begin
      next_delay = quad[delay_width-1:0];
    end
  end

  // last cycle of the wait
  assign due = running && (count <= delay_t'(1));

  always_ff @(posedge clk) begin
    if (reset) begin
      // first wait starts with reset release, at the longest delay
      cur_delay <= delay_t'(delay_inactive);
      count     <= delay_t'(delay_inactive);
      running   <= 1'b1;
    end else if (kick) begin
      cur_delay <= next_delay;
      count     <= next_delay;
      running   <= 1'b1;
    end else if (running) begin
      count <= count - 1'b1;
      // one due pulse, then idle until the next kick
      if (due) begin
        running <= 1'b0;
      end
    end
  end

endmodule

//--- design/multisim_cmd_fetch.sv
// command fetch: drives the host poll strobe and registers the host answer
`timescale 1ns/1ps

module multisim_cmd_fetch
  import multisim_msg_pkg::*;
(
  input  logic                     clk,
  input  logic                     reset,
  multisim_poll_if.responder       link,
  output logic                     cmd_poll,
  input  logic                     cmd_answer,
  input  logic                     cmd_hit,
  input  cmd_t                     cmd_data
);

  // a poll went out and has not been answered yet
  logic outstanding;
  // host answer that belongs to the outstanding poll
  logic accept;

  // answers with no poll in flight are dropped here,
  // the core never sees them
  assign accept = cmd_answer && outstanding;

  // control path
  always_ff @(posedge clk) begin
    if (reset) begin
      cmd_poll    <= 1'b0;
      outstanding <= 1'b0;
      link.answer <= 1'b0;
    end else begin
      // host strobe one cycle behind the core request
      cmd_poll    <= link.poll;
      // core sees the answer one cycle after the host
      link.answer <= accept;
      // open on the request, so an answer in the same
      // cycle as cmd_poll is still taken
      if (link.poll) begin
        outstanding <= 1'b1;
      end else if (accept) begin
        outstanding <= 1'b0;
      end
    end
  end

  // answer payload, held until the next accepted answer
  always_ff @(posedge clk) begin
    if (accept) begin
      link.hit <= cmd_hit;
      link.cmd <= cmd_data;
    end
  end

endmodule

//--- design/multisim_server_core.sv
// server core: sequences poll, command pull to the client and response push
`timescale 1ns/1ps

module multisim_server_core
  import multisim_msg_pkg::*;
(
  input  logic                     clk,
  input  logic                     reset,
  multisim_poll_if.requester       link,
  output logic                     pull_vld,
  input  logic                     pull_rdy,
  output cmd_t                     pull_data,
  output logic                     rsp_arm,
  input  logic                     rsp_done
);

  // one transaction at a time, pull then push
  typedef enum logic [1:0] {
    st_wait,          // scheduler wait running
    st_await_answer,  // poll out, host has not answered
    st_present,       // command offered to the client
    st_await_rsp      // command taken, waiting for the client response
  } state_t;

  state_t state;

  // scheduler handshake
  logic kick;
  logic hit_kick;
  logic due;

  // answer that carries a command
  logic take_cmd;

  multisim_poll_scheduler u_poll_scheduler (
    .clk      (clk),
    .reset    (reset),
    .kick     (kick),
    .hit_kick (hit_kick),
    .due      (due)
  );

  assign take_cmd = (state == st_await_answer) && link.answer && link.hit;

  // empty poll backs off, a finished transaction restarts the short wait
  // no kick while a transaction is open, so no extra poll goes out
  assign kick = ((state == st_await_answer) && link.answer && !link.hit) ||
                ((state == st_await_rsp) && rsp_done);
  assign hit_kick = (state == st_await_rsp);

  // pull handshake opens the response side, pull_vld is high in st_present
  assign rsp_arm = (state == st_present) && pull_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= st_wait;
      link.poll <= 1'b0;
      pull_vld  <= 1'b0;
    end else begin
      // poll is a single cycle strobe
      link.poll <= 1'b0;
      case (state)
        st_wait: begin
          if (due) begin
            link.poll <= 1'b1;
            state     <= st_await_answer;
          end
        end
        st_await_answer: begin
          if (link.answer) begin
            if (link.hit) begin
              pull_vld <= 1'b1;
              state    <= st_present;
            end else begin
              state <= st_wait;
            end
          end
        end
        st_present: begin
          // hold vld and data until the client takes them
          if (pull_rdy) begin
            pull_vld <= 1'b0;
            state    <= st_await_rsp;
          end
        end
        st_await_rsp: begin
          if (rsp_done) begin
            state <= st_wait;
          end
        end
        default: begin
          state <= st_wait;
        end
      endcase
    end
  end

  // command word for the client, stable through back-pressure
  always_ff @(posedge clk) begin
    if (take_cmd) begin
      pull_data <= link.cmd;
    end
  end

endmodule

//--- design/multisim_rsp_return.sv
// response return: takes one client response and strobes it out to the host
`timescale 1ns/1ps

module multisim_rsp_return
  import multisim_msg_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic rsp_arm,
  output logic rsp_done,
  output logic push_rdy,
  input  logic push_vld,
  input  rsp_t push_data,
  output logic rsp_strobe,
  output rsp_t rsp_data
);

  // client handshake on this edge
  logic push_fire;

  assign push_fire = push_vld && push_rdy;

  // control path
  always_ff @(posedge clk) begin
    if (reset) begin
      push_rdy   <= 1'b0;
      rsp_strobe <= 1'b0;
    end else begin
      // rdy opens one cycle after arming, closes after one word
      if (push_fire) begin
        push_rdy <= 1'b0;
      end else if (rsp_arm) begin
        push_rdy <= 1'b1;
      end
      // host has no back-pressure, one strobe per response
      rsp_strobe <= push_fire;
    end
  end

  // response word, valid with rsp_strobe
  always_ff @(posedge clk) begin
    if (push_fire) begin
      rsp_data <= push_data;
    end
  end

  // core closes the transaction on the same cycle the host sees the strobe
  assign rsp_done = rsp_strobe;

endmodule

//--- design/multisim_server_top.sv
// pull then push server bridge: host polling side, client side and return path
`timescale 1ns/1ps

module multisim_server_top
  import multisim_msg_pkg::*;
(
  input  logic clk,
  input  logic reset,
  // host command side, single cycle strobes
  output logic cmd_poll,
  input  logic cmd_answer,
  input  logic cmd_hit,
  input  cmd_t cmd_data,
  // host response side, no back-pressure
  output logic rsp_strobe,
  output rsp_t rsp_data,
  // client command pull, valid/ready
  output logic pull_vld,
  input  logic pull_rdy,
  output cmd_t pull_data,
  // client response push, valid/ready
  output logic push_rdy,
  input  logic push_vld,
  input  rsp_t push_data
);

  // core opens the return path for one response
  logic rsp_arm;
  // return path took the response
  logic rsp_done;

  // poll request and host answer between core and fetch
  multisim_poll_if u_poll_if ();

  multisim_cmd_fetch u_cmd_fetch (
    .clk        (clk),
    .reset      (reset),
    .link       (u_poll_if.responder),
    .cmd_poll   (cmd_poll),
    .cmd_answer (cmd_answer),
    .cmd_hit    (cmd_hit),
    .cmd_data   (cmd_data)
  );

  multisim_server_core u_server_core (
    .clk       (clk),
    .reset     (reset),
    .link      (u_poll_if.requester),
    .pull_vld  (pull_vld),
    .pull_rdy  (pull_rdy),
    .pull_data (pull_data),
    .rsp_arm   (rsp_arm),
    .rsp_done  (rsp_done)
  );

  multisim_rsp_return u_rsp_return (
    .clk        (clk),
    .reset      (reset),
    .rsp_arm    (rsp_arm),
    .rsp_done   (rsp_done),
    .push_rdy   (push_rdy),
    .push_vld   (push_vld),
    .push_data  (push_data),
    .rsp_strobe (rsp_strobe),
    .rsp_data   (rsp_data)
  );

endmodule

//--- testbench/tb_multisim_server.sv
// testbench for the poll server bridge where host and client models replay the cases file
`timescale 1ns/1ps

module tb_multisim_server
  import multisim_cfg_pkg::*;
  import multisim_msg_pkg::*;
();

  localparam int clk_period = 20;
  localparam int max_cases = 64;
  // words per line of the cases file
  localparam int fields = 6;

  logic clk;
  logic reset;
  logic cmd_poll;
  logic cmd_answer;
  logic cmd_hit;
  cmd_t cmd_data;
  logic rsp_strobe;
  rsp_t rsp_data;
  logic pull_vld;
  logic pull_rdy;
  cmd_t pull_data;
  logic push_rdy;
  logic push_vld;
  rsp_t push_data;

  logic [31:0] case_mem [0:max_cases*fields-1];
  int num_cases = 0;
  logic cases_ready = 1'b0;
  integer seed = 35316;

  int errors = 0;
  int case_errors = 0;
  int cases_failed = 0;
  int watch_cycles = 0;

  // rising edges since time zero and only read on the falling edge
  int edge_cnt = 0;
  // reference model of the poll timing
  int cur_delay = 0;
  int exp_poll = 0;
  int polls_seen = 0;

  // counts kept by the monitor
  int mon_polls = 0;
  int mon_strobes = 0;
  int mon_pull_rises = 0;
  logic pull_vld_q = 1'b0;

  multisim_server_top u_multisim_server_top (
    .clk        (clk),
    .reset      (reset),
    .cmd_poll   (cmd_poll),
    .cmd_answer (cmd_answer),
    .cmd_hit    (cmd_hit),
    .cmd_data   (cmd_data),
    .rsp_strobe (rsp_strobe),
    .rsp_data   (rsp_data),
    .pull_vld   (pull_vld),
    .pull_rdy   (pull_rdy),
    .pull_data  (pull_data),
    .push_rdy   (push_rdy),
    .push_vld   (push_vld),
    .push_data  (push_data)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period/2) clk = ~clk;
  end

  // sampled on the rising edge, so each count covers the cycle that just ended
  always @(posedge clk) begin
    edge_cnt = edge_cnt + 1;
    if (cmd_poll === 1'b1) begin
      mon_polls = mon_polls + 1;
    end
    if (rsp_strobe === 1'b1) begin
      mon_strobes = mon_strobes + 1;
    end
    if (pull_vld === 1'b1 && pull_vld_q !== 1'b1) begin
      mon_pull_rises = mon_pull_rises + 1;
    end
    pull_vld_q = pull_vld;
  end

  // backoff step after an empty poll, zero counts as one
  function automatic int next_miss_delay(input int cur);
    int base;
    base = (cur == 0) ? 1 : cur;
    if (base * 4 > delay_inactive) begin
      return delay_inactive;
    end
    return base * 4;
  endfunction

  task automatic flag_mismatch(input string sig, input logic [31:0] exp,
                               input logic [31:0] got);
    $display("[ERROR] t=%0d ns: %s expected 0x%0h, got 0x%0h", $time, sig, exp, got);
    errors++;
    case_errors++;
  endtask

  task automatic flag_problem(input string what);
    $display("[ERROR] t=%0d ns: %s", $time, what);
    errors++;
    case_errors++;
  endtask

  // wait for cmd_poll and compare its edge with the model
  task automatic await_poll();
    int limit;
    int waited;
    logic quiet_ok;
    limit = exp_poll - edge_cnt + 8;
    if (limit < 8) begin
      limit = 8;
    end
    waited = 0;
    quiet_ok = 1'b1;
    while (cmd_poll !== 1'b1 && waited < limit) begin
      // no client or response activity while the scheduler waits
      if (quiet_ok && (pull_vld !== 1'b0 || push_rdy !== 1'b0 || rsp_strobe !== 1'b0)) begin
        flag_problem("a control output went high while waiting for a poll");
        quiet_ok = 1'b0;
      end
      @(negedge clk);
      waited++;
    end
    if (cmd_poll !== 1'b1) begin
      flag_problem($sformatf("no cmd_poll within %0d cycles", limit));
    end else begin
      polls_seen++;
      if (edge_cnt != exp_poll) begin
        flag_mismatch("cmd_poll edge", exp_poll, edge_cnt);
      end
    end
  endtask

  // host answers the poll after lat cycles
  task automatic host_answer(input int lat, input logic hit, input cmd_t word,
                             output int ans_edge);
    repeat (lat) @(negedge clk);
    cmd_answer = 1'b1;
    cmd_hit = hit;
    cmd_data = word;
    ans_edge = edge_cnt + 1;
    @(negedge clk);
    cmd_answer = 1'b0;
    cmd_hit = 1'b0;
  endtask

  // client takes the command under back-pressure, then pushes the response
  task automatic serve_client(input cmd_t cmd_word, input int rdy_dly, input int push_dly,
                              input rsp_t rsp_word);
    int hold;
    int waited;
    int i;
    hold = rdy_dly + ($random(seed) & 3);
    @(negedge clk);
    // command stays on the bus through the whole stretch
    for (i = 0; i <= hold; i++) begin
      if (pull_vld !== 1'b1) begin
        flag_mismatch("pull_vld", 1, pull_vld);
      end
      if (pull_data !== cmd_word) begin
        flag_mismatch("pull_data", cmd_word, pull_data);
      end
      if (i == hold) begin
        pull_rdy = 1'b1;
      end
      @(negedge clk);
    end
    pull_rdy = 1'b0;
    if (pull_vld !== 1'b0) begin
      flag_mismatch("pull_vld", 0, pull_vld);
    end
    repeat (push_dly + ($random(seed) & 3)) @(negedge clk);
    push_vld = 1'b1;
    push_data = rsp_word;
    waited = 0;
    while (push_rdy !== 1'b1 && waited < 16) begin
      @(negedge clk);
      waited++;
    end
    if (push_rdy !== 1'b1) begin
      flag_problem("push_rdy never rose after the pull handshake");
      push_vld = 1'b0;
    end else begin
      @(negedge clk);
      push_vld = 1'b0;
      push_data = ~rsp_word;
      // push handshake was on the edge just passed
      if (rsp_strobe !== 1'b1) begin
        flag_mismatch("rsp_strobe", 1, rsp_strobe);
      end
      if (rsp_data !== rsp_word) begin
        flag_mismatch("rsp_data", rsp_word, rsp_data);
      end
      cur_delay = delay_active;
      exp_poll = edge_cnt + delay_active + 2;
      @(negedge clk);
      if (rsp_strobe !== 1'b0) begin
        flag_mismatch("rsp_strobe", 0, rsp_strobe);
      end
      if (push_rdy !== 1'b0) begin
        flag_mismatch("push_rdy", 0, push_rdy);
      end
    end
  endtask

  initial begin
    wait (cases_ready === 1'b1);
    #(watch_cycles * clk_period);
    $display("watchdog expired after %0d cycles, the DUT stopped making progress",
             watch_cycles);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    int base;
    int idx;
    int misses;
    int lat;
    int rdy_dly;
    int push_dly;
    int ans_edge;
    cmd_t cmd_word;
    rsp_t rsp_word;
    reset = 1'b1;
    cmd_answer = 1'b0;
    cmd_hit = 1'b0;
    cmd_data = '0;
    pull_rdy = 1'b0;
    push_vld = 1'b0;
    push_data = '0;

    $readmemh("testbench/multisim_cases.txt", case_mem);
    while (num_cases < max_cases && !$isunknown(case_mem[num_cases*fields])) begin
      num_cases++;
    end
    // worst backoff, latency and client delays per case plus reset and margin
    watch_cycles = 2 * delay_inactive + 200;
    for (idx = 0; idx < num_cases; idx++) begin
      base = idx * fields;
      watch_cycles += (int'(case_mem[base]) + 1) *
                      (delay_inactive + int'(case_mem[base+1]) + 8);
      watch_cycles += int'(case_mem[base+3]) + int'(case_mem[base+4]) + 20;
    end
    cases_ready = 1'b1;
    if (num_cases == 0) begin
      flag_problem("the cases file is missing or holds no cases");
    end

    repeat (8) @(negedge clk);
    reset = 1'b0;
    // first wait is loaded on the last reset edge
    cur_delay = delay_inactive;
    exp_poll = edge_cnt + delay_inactive + 1;

    for (idx = 0; idx < num_cases; idx++) begin
      base = idx * fields;
      misses = int'(case_mem[base]);
      lat = int'(case_mem[base+1]);
      cmd_word = case_mem[base+2];
      rdy_dly = int'(case_mem[base+3]);
      push_dly = int'(case_mem[base+4]);
      rsp_word = case_mem[base+5];
      case_errors = 0;
      repeat (misses) begin
        await_poll();
        host_answer(lat, 1'b0, cmd_t'($random(seed)), ans_edge);
        cur_delay = next_miss_delay(cur_delay);
        exp_poll = ans_edge + cur_delay + 2;
        // stray answer on the edge before cmd_poll rises
        // no poll is outstanding yet so fetch has to drop it
        while (edge_cnt < exp_poll - 2) begin
          @(negedge clk);
        end
        cmd_answer = 1'b1;
        cmd_hit = 1'b1;
        cmd_data = ~cmd_word;
        @(negedge clk);
        cmd_answer = 1'b0;
        cmd_hit = 1'b0;
      end
      await_poll();
      host_answer(lat, 1'b1, cmd_word, ans_edge);
      serve_client(cmd_word, rdy_dly, push_dly, rsp_word);
      // one pull and one strobe per transaction and no poll in between
      if (mon_strobes != idx + 1) begin
        flag_mismatch("rsp_strobe count", idx + 1, mon_strobes);
      end
      if (mon_pull_rises != idx + 1) begin
        flag_mismatch("pull_vld rise count", idx + 1, mon_pull_rises);
      end
      if (mon_polls != polls_seen) begin
        flag_mismatch("cmd_poll count", polls_seen, mon_polls);
      end
      if (case_errors == 0) begin
        $display("case %0d ok: %0d misses, cmd %h, rsp %h", idx, misses, cmd_word, rsp_word);
      end else begin
        $display("case %0d failed with %0d errors", idx, case_errors);
        cases_failed++;
      end
    end
    // the last response is followed by a poll after the short wait
    await_poll();

    $display("%0d cases run, %0d failed, %0d errors", num_cases, cases_failed, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- list.f
design/multisim_cfg_pkg.sv
design/multisim_msg_pkg.sv
design/multisim_poll_if.sv
design/multisim_poll_scheduler.sv
design/multisim_cmd_fetch.sv
design/multisim_server_core.sv
design/multisim_rsp_return.sv
design/multisim_server_top.sv
testbench/tb_multisim_server.sv

//--- Bender.yml
package:
  name: multisim_server

sources:
  # message types build on the configuration package
  - design/multisim_cfg_pkg.sv
  - design/multisim_msg_pkg.sv
  - design/multisim_poll_if.sv
  - design/multisim_poll_scheduler.sv
  - design/multisim_cmd_fetch.sv
  - design/multisim_server_core.sv
  - design/multisim_rsp_return.sv
  - design/multisim_server_top.sv
  - target: test
    files:
      - testbench/tb_multisim_server.sv

//--- testbench/multisim_cases.txt
// misses before the hit, host answer latency, command word, pull_rdy delay, push delay,
// response word; all fields hex, latency and delays in clock cycles
2 1 a5a50001 0 0 5a5a0001
1 3 deadbeef 2 1 0badf00d
2 0 00000000 0 0 ffffffff
3 1 12345678 1 2 87654321
0 2 ffffffff 4 0 00000000
4 0 0f0f0f0f 0 3 f0f0f0f0
1 5 80000001 3 3 7ffffffe
0 0 cafe0001 0 0 beef0001
0 1 cafe0002 1 0 beef0002
5 2 13579bdf 2 2 2468ace0
2 4 aaaaaaaa 0 1 55555555
0 0 00000001 5 5 00000002
1 0 fedcba98 1 4 89abcdef
3 3 01234567 0 0 76543210
0 2 c0ffee00 2 1 00eeffc0
2 1 11111111 3 0 22222222
1 1 33333333 0 2 44444444
0 0 55aa55aa 0 0 aa55aa55
4 2 9abcdef0 1 1 0fedcba9
1 0 76543210 4 2 01234567
0 3 5eed0001 2 3 1eaf0001
2 2 d00dfeed 1 0 feedd00d
